/* Bender.yml */
package:
  name: fpu

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_pkg.sv
      - logic/fp_issue_stage.sv
      - logic/fp_compare_unit.sv
      - logic/fp_sign_class_unit.sv
      - logic/fp_result_stage.sv
      - logic/fpu_top.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_fpu.sv

/* compile.f */
+incdir+logic
logic/fpu_pkg.sv
logic/fp_issue_stage.sv
logic/fp_compare_unit.sv
logic/fp_sign_class_unit.sv
logic/fp_result_stage.sv
logic/fpu_top.sv
verif/tb_clock_gen.sv
verif/tb_fpu.sv

/* logic/fp_compare_unit.sv */
/*
 * Compare unit: FEQ, FLT, FLE, FMIN and FMAX on single precision
 * operands, with NaN handling and the invalid flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_compare_unit import fpu_pkg::*; (
    input  fpu_op_e      op_i,
    input  float_t       operand_a_i,
    input  float_t       operand_b_i,
    input  float_class_t class_a_i,
    input  float_class_t class_b_i,

    output float_t       result_o,
    output logic         invalid_o
);

// ======================================================================
// Shared relations
// ======================================================================

    logic nan_a;
    logic nan_b;
    logic any_nan;
    logic any_snan;
    logic both_zero;
    logic equal;
    logic a_below_b;
    logic less;
    logic mag_a_lt_b;
    logic mag_b_lt_a;

    assign nan_a    = class_a_i.is_snan | class_a_i.is_qnan;
    assign nan_b    = class_b_i.is_snan | class_b_i.is_qnan;
    assign any_nan  = nan_a | nan_b;
    assign any_snan = class_a_i.is_snan | class_b_i.is_snan;

    // +0 and -0 compare equal
    assign both_zero = class_a_i.is_zero & class_b_i.is_zero;
    assign equal     = (operand_a_i == operand_b_i) | both_zero;

    // Magnitude order from exponent and mantissa taken together
    assign mag_a_lt_b = {operand_a_i.exponent, operand_a_i.mantissa}
                      < {operand_b_i.exponent, operand_b_i.mantissa};
    assign mag_b_lt_a = {operand_b_i.exponent, operand_b_i.mantissa}
                      < {operand_a_i.exponent, operand_a_i.mantissa};

    // Sign magnitude order, -0 sits below +0 here
    always_comb begin
        case ({operand_a_i.sign, operand_b_i.sign})
            2'b10:   a_below_b = 1'b1;
            2'b01:   a_below_b = 1'b0;
            2'b00:   a_below_b = mag_a_lt_b;
            default: a_below_b = mag_b_lt_a;
        endcase
    end

    // Strict order for FLT and FLE ignores the zero sign
    assign less = a_below_b & ~both_zero;

// ======================================================================
// Operation select
// ======================================================================

    always_comb begin
        result_o  = '0;
        invalid_o = 1'b0;
        case (op_i)
            FEQ: begin
                result_o  = float_t'({{(`FPU_FLOAT_WIDTH-1){1'b0}}, equal & ~any_nan});
                invalid_o = any_snan;
            end
            FLT: begin
                result_o  = float_t'({{(`FPU_FLOAT_WIDTH-1){1'b0}}, less & ~any_nan});
                invalid_o = any_nan;
            end
            FLE: begin
                result_o  = float_t'({{(`FPU_FLOAT_WIDTH-1){1'b0}},
                                      (less | equal) & ~any_nan});
                invalid_o = any_nan;
            end
            FMIN, FMAX: begin
                // A single NaN yields the other operand
                if (nan_a && nan_b) begin
                    result_o = float_t'(`FPU_CANONICAL_NAN);
                end else if (nan_a) begin
                    result_o = operand_b_i;
                end else if (nan_b) begin
                    result_o = operand_a_i;
                end else if (a_below_b == (op_i == FMIN)) begin
                    result_o = operand_a_i;
                end else begin
                    result_o = operand_b_i;
                end
                invalid_o = any_snan;
            end
            default: begin
                result_o  = '0;
                invalid_o = 1'b0;
            end
        endcase
    end

endmodule : fp_compare_unit

`default_nettype wire

/* logic/fp_issue_stage.sv */
/*
 * Issue stage: first pipeline register of the FPU.
 * Classifies both operands, decodes the target unit
 * and carries the instruction tag.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_issue_stage import fpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,

    input  logic                      valid_i,
    input  fpu_op_e                   operation_i,
    input  float_t                    operand_a_i,
    input  float_t                    operand_b_i,
    input  logic [`FPU_TAG_WIDTH-1:0] tag_i,

    output fpu_op_e                   op_o,
    output float_t                    operand_a_o,
    output float_t                    operand_b_o,
    output float_class_t              class_a_o,
    output float_class_t              class_b_o,
    output logic [`FPU_TAG_WIDTH-1:0] tag_o,
    output logic                      cmp_valid_o,
    output logic                      misc_valid_o
);

// ======================================================================
// Unit decode
// ======================================================================

    logic is_cmp_op;
    logic is_misc_op;

    // Unknown encodings select no unit and are dropped
    always_comb begin
        is_cmp_op  = 1'b0;
        is_misc_op = 1'b0;
        case (operation_i)
            FEQ, FLT, FLE, FMIN, FMAX:     is_cmp_op  = 1'b1;
            FSGNJ, FSGNJN, FSGNJX, FCLASS: is_misc_op = 1'b1;
            default: begin
                is_cmp_op  = 1'b0;
                is_misc_op = 1'b0;
            end
        endcase
    end

// ======================================================================
// Pipeline register
// ======================================================================

    // Flush wins over stall
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmp_valid_o  <= 1'b0;
            misc_valid_o <= 1'b0;
        end else if (flush_i) begin
            cmp_valid_o  <= 1'b0;
            misc_valid_o <= 1'b0;
        end else if (!stall_i) begin
            cmp_valid_o  <= valid_i & is_cmp_op;
            misc_valid_o <= valid_i & is_misc_op;
        end
    end

    // Payload, classification is done before the register
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            op_o        <= operation_i;
            operand_a_o <= operand_a_i;
            operand_b_o <= operand_b_i;
            class_a_o   <= classify_float(operand_a_i);
            class_b_o   <= classify_float(operand_b_i);
            tag_o       <= tag_i;
        end
    end

    // At most one execution unit owns an issued operation
    one_unit_per_op: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(cmp_valid_o && misc_valid_o)
    );

endmodule : fp_issue_stage

`default_nettype wire

/* logic/fp_result_stage.sv */
/*
 * Result stage: second pipeline register of the FPU.
 * Picks the active unit result and registers it with
 * valid, invalid and the tag.
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_result_stage import fpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,

    input  logic                      cmp_valid_i,
    input  logic                      misc_valid_i,
    input  float_t                    cmp_result_i,
    input  float_t                    misc_result_i,
    input  logic                      cmp_invalid_i,
    input  logic [`FPU_TAG_WIDTH-1:0] tag_i,

    output float_t                    result_o,
    output logic [`FPU_TAG_WIDTH-1:0] tag_o,
    output logic                      valid_o,
    output logic                      invalid_o
);

    logic                      unit_active;
    float_t                    next_result;
    logic [`FPU_TAG_WIDTH-1:0] next_tag;
    logic                      next_invalid;

    assign unit_active = cmp_valid_i | misc_valid_i;

    // Idle cycles present all zeros
    always_comb begin
        if (cmp_valid_i) begin
            next_result = cmp_result_i;
        end else if (misc_valid_i) begin
            next_result = misc_result_i;
        end else begin
            next_result = '0;
        end
    end

    assign next_tag     = unit_active ? tag_i : '0;
    assign next_invalid = cmp_valid_i & cmp_invalid_i;

    // Outputs are cleared on flush too, so nothing stale shows
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            result_o  <= '0;
            tag_o     <= '0;
            valid_o   <= 1'b0;
            invalid_o <= 1'b0;
        end else if (!stall_i) begin
            result_o  <= next_result;
            tag_o     <= next_tag;
            valid_o   <= unit_active;
            invalid_o <= next_invalid;
        end
    end

    invalid_needs_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        invalid_o |-> valid_o
    );

endmodule : fp_result_stage

`default_nettype wire

/* logic/fp_sign_class_unit.sv */
/*
 * Miscellaneous unit: FSGNJ, FSGNJN and FSGNJX sign injection
 * and the ten-bit FCLASS mask
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fp_sign_class_unit import fpu_pkg::*; (
    input  fpu_op_e      op_i,
    input  float_t       operand_a_i,
    input  float_t       operand_b_i,
    input  float_class_t class_a_i,

    output float_t       result_o
);

// ======================================================================
// Class mask
// ======================================================================

    logic                        is_nan;
    logic                        is_normal;
    logic                        neg;
    logic [`FPU_CLASS_WIDTH-1:0] class_mask;

    assign is_nan    = class_a_i.is_snan | class_a_i.is_qnan;
    assign is_normal = ~(class_a_i.is_inf | class_a_i.is_zero
                         | class_a_i.is_subnormal | is_nan);
    assign neg       = operand_a_i.sign;

    // One hot, negative classes in the low half
    assign class_mask[0] = neg & class_a_i.is_inf;
    assign class_mask[1] = neg & is_normal;
    assign class_mask[2] = neg & class_a_i.is_subnormal;
    assign class_mask[3] = neg & class_a_i.is_zero;
    assign class_mask[4] = ~neg & class_a_i.is_zero;
    assign class_mask[5] = ~neg & class_a_i.is_subnormal;
    assign class_mask[6] = ~neg & is_normal;
    assign class_mask[7] = ~neg & class_a_i.is_inf;
    // NaN classes ignore the sign
    assign class_mask[8] = class_a_i.is_snan;
    assign class_mask[9] = class_a_i.is_qnan;

// ======================================================================
// Operation select
// ======================================================================

    always_comb begin
        // Sign injection keeps the magnitude of A
        result_o = operand_a_i;
        case (op_i)
            FSGNJ:  result_o.sign = operand_b_i.sign;
            FSGNJN: result_o.sign = ~operand_b_i.sign;
            FSGNJX: result_o.sign = operand_a_i.sign ^ operand_b_i.sign;
            FCLASS: begin
                result_o = float_t'({{(`FPU_FLOAT_WIDTH-`FPU_CLASS_WIDTH){1'b0}},
                                     class_mask});
            end
            default: result_o = '0;
        endcase
    end

endmodule : fp_sign_class_unit

`default_nettype wire

/* logic/fpu_defines.svh */
/*
 * Single precision field widths, instruction tag width
 * and the constant values shared by the FPU blocks
 */

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// =====================================================================
// Float format
// =====================================================================

`define FPU_FLOAT_WIDTH 32
`define FPU_EXP_WIDTH 8
`define FPU_MANT_WIDTH 23

// Positive quiet NaN, only the top mantissa bit set
`define FPU_CANONICAL_NAN 32'h7FC0_0000

// Number of bits in the FCLASS result mask
`define FPU_CLASS_WIDTH 10

// =====================================================================
// Instruction tag
// =====================================================================

`define FPU_TAG_WIDTH 6

`endif

/* logic/fpu_pkg.sv */
/*
 * FPU types: float layout, opcode enum, operand class flags
 * and the classify_float function
 */

`default_nettype none

`include "fpu_defines.svh"

package fpu_pkg;

    // IEEE 754 single precision layout
    typedef struct packed {
        logic                       sign;
        logic [`FPU_EXP_WIDTH-1:0]  exponent;
        logic [`FPU_MANT_WIDTH-1:0] mantissa;
    } float_t;

    // Compare group first, then the miscellaneous group
    typedef enum logic [3:0] {
        FEQ    = 4'd0,
        FLT    = 4'd1,
        FLE    = 4'd2,
        FMIN   = 4'd3,
        FMAX   = 4'd4,
        FSGNJ  = 4'd5,
        FSGNJN = 4'd6,
        FSGNJX = 4'd7,
        FCLASS = 4'd8
    } fpu_op_e;

    // A normal number has none of these flags set
    typedef struct packed {
        logic is_inf;
        logic is_zero;
        logic is_subnormal;
        logic is_snan;
        logic is_qnan;
    } float_class_t;

    function automatic float_class_t classify_float(input float_t value);
        float_class_t cls;
        logic         exp_ones;
        logic         exp_zero;
        logic         mant_zero;
        logic         quiet_bit;

        exp_ones  = &value.exponent;
        exp_zero  = ~|value.exponent;
        mant_zero = ~|value.mantissa;
        quiet_bit = value.mantissa[`FPU_MANT_WIDTH-1];

        cls.is_inf       = exp_ones & mant_zero;
        cls.is_zero      = exp_zero & mant_zero;
        cls.is_subnormal = exp_zero & ~mant_zero;
        // NaN payload with the quiet bit clear is signaling
        cls.is_qnan      = exp_ones & quiet_bit;
        cls.is_snan      = exp_ones & ~quiet_bit & ~mant_zero;
        return cls;
    endfunction

endpackage : fpu_pkg

`default_nettype wire

/* logic/fpu_top.sv */
/*
 * FPU top level: issue stage, compare unit,
 * sign and class unit, result stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_top import fpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      flush_i,

    input  logic                      valid_i,
    input  fpu_op_e                   operation_i,
    input  float_t                    operand_a_i,
    input  float_t                    operand_b_i,
    input  logic [`FPU_TAG_WIDTH-1:0] tag_i,

    output float_t                    result_o,
    output logic [`FPU_TAG_WIDTH-1:0] tag_o,
    output logic                      valid_o,
    output logic                      invalid_o
);

// ======================================================================
// Issue
// ======================================================================

    fpu_op_e                   issue_op;
    float_t                    issue_operand_a;
    float_t                    issue_operand_b;
    float_class_t              issue_class_a;
    float_class_t              issue_class_b;
    logic [`FPU_TAG_WIDTH-1:0] issue_tag;
    logic                      cmp_valid;
    logic                      misc_valid;

    fp_issue_stage issue_stage_i (
        .clk_i        ( clk_i           ),
        .rst_n_i      ( rst_n_i         ),
        .stall_i      ( stall_i         ),
        .flush_i      ( flush_i         ),
        .valid_i      ( valid_i         ),
        .operation_i  ( operation_i     ),
        .operand_a_i  ( operand_a_i     ),
        .operand_b_i  ( operand_b_i     ),
        .tag_i        ( tag_i           ),
        .op_o         ( issue_op        ),
        .operand_a_o  ( issue_operand_a ),
        .operand_b_o  ( issue_operand_b ),
        .class_a_o    ( issue_class_a   ),
        .class_b_o    ( issue_class_b   ),
        .tag_o        ( issue_tag       ),
        .cmp_valid_o  ( cmp_valid       ),
        .misc_valid_o ( misc_valid      )
    );

// ======================================================================
// Execution units
// ======================================================================

    float_t cmp_result;
    logic   cmp_invalid;
    float_t misc_result;

    fp_compare_unit compare_unit_i (
        .op_i        ( issue_op        ),
        .operand_a_i ( issue_operand_a ),
        .operand_b_i ( issue_operand_b ),
        .class_a_i   ( issue_class_a   ),
        .class_b_i   ( issue_class_b   ),
        .result_o    ( cmp_result      ),
        .invalid_o   ( cmp_invalid     )
    );

    // Only operand A is classified for FCLASS
    fp_sign_class_unit sign_class_unit_i (
        .op_i        ( issue_op        ),
        .operand_a_i ( issue_operand_a ),
        .operand_b_i ( issue_operand_b ),
        .class_a_i   ( issue_class_a   ),
        .result_o    ( misc_result     )
    );

// ======================================================================
// Result
// ======================================================================

    fp_result_stage result_stage_i (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .stall_i       ( stall_i     ),
        .flush_i       ( flush_i     ),
        .cmp_valid_i   ( cmp_valid   ),
        .misc_valid_i  ( misc_valid  ),
        .cmp_result_i  ( cmp_result  ),
        .misc_result_i ( misc_result ),
        .cmp_invalid_i ( cmp_invalid ),
        .tag_i         ( issue_tag   ),
        .result_o      ( result_o    ),
        .tag_o         ( tag_o       ),
        .valid_o       ( valid_o     ),
        .invalid_o     ( invalid_o   )
    );

endmodule : fpu_top

`default_nettype wire

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset generator.
 * 100 ns clock, reset held low over two rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release a little after the second edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #10;
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

/* verif/tb_fpu.sv */
/*
 * Directed testbench for fpu_top covering compare, min/max, sign injection,
 * class mask and pipeline behavior, with reference rules,
 * a Galois LFSR for random operands and a result summary
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module tb_fpu import fpu_pkg::*; ();

    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      stall;
    logic                      flush;
    logic                      valid;
    fpu_op_e                   operation;
    float_t                    operand_a;
    float_t                    operand_b;
    logic [`FPU_TAG_WIDTH-1:0] tag;
    float_t                    result;
    logic [`FPU_TAG_WIDTH-1:0] tag_out;
    logic                      valid_out;
    logic                      invalid_out;

    int          tests_passed;
    int          tests_failed;
    int          test_errors;
    logic [15:0] lfsr_state;

    tb_clock_gen clock_gen_i (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    fpu_top fpu_top_i (
        .clk_i       ( clk         ),
        .rst_n_i     ( rst_n       ),
        .stall_i     ( stall       ),
        .flush_i     ( flush       ),
        .valid_i     ( valid       ),
        .operation_i ( operation   ),
        .operand_a_i ( operand_a   ),
        .operand_b_i ( operand_b   ),
        .tag_i       ( tag         ),
        .result_o    ( result      ),
        .tag_o       ( tag_out     ),
        .valid_o     ( valid_out   ),
        .invalid_o   ( invalid_out )
    );

// ======================================================================
// Reference rules
// ======================================================================

    function automatic logic is_nan(input float_t x);
        return (x.exponent == '1) && (x.mantissa != '0);
    endfunction

    function automatic logic is_snan(input float_t x);
        return is_nan(x) && !x.mantissa[`FPU_MANT_WIDTH-1];
    endfunction

    function automatic logic is_zero(input float_t x);
        return (x.exponent == '0) && (x.mantissa == '0);
    endfunction

    // Monotone unsigned key where -0 lands just below +0
    function automatic logic [31:0] order_key(input float_t x);
        return x.sign ? ~32'(x) : (32'(x) | 32'h8000_0000);
    endfunction

    // Returns {invalid, result}
    function automatic logic [32:0] expected_compare(input fpu_op_e op,
                                                     input float_t a, input float_t b);
        logic        nan_a;
        logic        nan_b;
        logic        snan;
        logic        zeros;
        logic        eq;
        logic        lt;
        logic [31:0] pick;

        nan_a = is_nan(a);
        nan_b = is_nan(b);
        snan  = is_snan(a) || is_snan(b);
        zeros = is_zero(a) && is_zero(b);
        eq    = (a == b) || zeros;
        lt    = (order_key(a) < order_key(b)) && !zeros;
        case (op)
            FEQ:     return {snan, 31'd0, eq && !(nan_a || nan_b)};
            FLT:     return {nan_a || nan_b, 31'd0, lt && !(nan_a || nan_b)};
            FLE:     return {nan_a || nan_b, 31'd0, (lt || eq) && !(nan_a || nan_b)};
            default: begin
                if (nan_a && nan_b) pick = `FPU_CANONICAL_NAN;
                else if (nan_a) pick = b;
                else if (nan_b) pick = a;
                else if ((order_key(a) <= order_key(b)) == (op == FMIN)) pick = a;
                else pick = b;
                return {snan, pick};
            end
        endcase
    endfunction

    function automatic logic [31:0] expected_sign(input fpu_op_e op,
                                                  input float_t a, input float_t b);
        logic s;

        case (op)
            FSGNJ:   s = b.sign;
            FSGNJN:  s = !b.sign;
            default: s = a.sign ^ b.sign;
        endcase
        return {s, a[30:0]};
    endfunction

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

// ======================================================================
// Drive and check helpers
// ======================================================================

    task automatic drive_op(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input logic [`FPU_TAG_WIDTH-1:0] t);
        @(posedge clk);
        #DRIVE_DELAY;
        valid     = 1'b1;
        operation = op;
        operand_a = a;
        operand_b = b;
        tag       = t;
    endtask

    task automatic go_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        valid = 1'b0;
    endtask

    task automatic expect_equal(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wait_for_valid(input string name);
        int cycles;

        cycles = 0;
        while (!valid_out && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        assert (valid_out) else begin
            $display("%s: valid_o never rose within %0d cycles", name, TIMEOUT_CYCLES);
            test_errors++;
        end
    endtask

    // One operation through the pipeline and its checks
    task automatic run_op(input string name, input fpu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic [`FPU_TAG_WIDTH-1:0] t,
                          input logic [31:0] exp_result, input logic exp_invalid);
        drive_op(op, a, b, t);
        go_idle();
        wait_for_valid(name);
        expect_equal(name, "result", exp_result, result);
        expect_equal(name, "invalid", exp_invalid, invalid_out);
        expect_equal(name, "tag", t, tag_out);
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

// ======================================================================
// Tests
// ======================================================================

    task automatic after_reset();
        int cycles;

        cycles = 0;
        while (!rst_n && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        assert (rst_n) else begin
            $display("after_reset: reset was never released");
            test_errors++;
        end
        expect_equal("after_reset", "valid", 0, valid_out);
        expect_equal("after_reset", "invalid", 0, invalid_out);
        expect_equal("after_reset", "result", 0, result);
        expect_equal("after_reset", "tag", 0, tag_out);
        close_test("after_reset");
    endtask

    task automatic compare_ops();
        logic [31:0] pa [0:7];
        logic [31:0] pb [0:7];
        fpu_op_e     ops [0:2];
        logic [32:0] exp;
        logic [5:0]  t;

        // Ordered pairs both ways, signed zeros, NaNs and negatives
        pa  = '{32'h3F80_0000, 32'h4000_0000, 32'hBF80_0000, 32'h3F80_0000,
                32'h0000_0000, 32'h7FC0_0000, 32'h3F80_0000, 32'hC060_0000};
        pb  = '{32'h4000_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0000,
                32'h8000_0000, 32'h3F80_0000, 32'h7F80_0001, 32'hBF80_0000};
        ops = '{FEQ, FLT, FLE};
        t   = 6'd1;
        for (int o = 0; o < 3; o++) begin
            for (int i = 0; i < 8; i++) begin
                exp = expected_compare(ops[o], pa[i], pb[i]);
                run_op("compare_ops", ops[o], pa[i], pb[i], t, exp[31:0], exp[32]);
                t++;
            end
        end
        close_test("compare_ops");
    endtask

    task automatic min_max_ops();
        logic [31:0] pa [0:7];
        logic [31:0] pb [0:7];
        logic [32:0] exp;
        logic [5:0]  t;

        pa = '{32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'h7FC0_0000,
               32'h7FC0_0000, 32'h7F80_0001, 32'h7F80_0001, 32'hC060_0000};
        pb = '{32'h8000_0000, 32'h0000_0000, 32'h7FC0_0000, 32'hBF80_0000,
               32'hFFC0_0000, 32'hFF80_0002, 32'h4000_0000, 32'h3F80_0000};
        t  = 6'h20;
        for (int i = 0; i < 8; i++) begin
            exp = expected_compare(FMIN, pa[i], pb[i]);
            run_op("min_max_ops", FMIN, pa[i], pb[i], t, exp[31:0], exp[32]);
            exp = expected_compare(FMAX, pa[i], pb[i]);
            run_op("min_max_ops", FMAX, pa[i], pb[i], t + 6'd1, exp[31:0], exp[32]);
            t = t + 6'd2;
        end
        close_test("min_max_ops");
    endtask

    task automatic sign_injection();
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  t;

        t = 6'd0;
        for (int i = 0; i < 32; i++) begin
            random_word(a);
            random_word(b);
            run_op("sign_injection", FSGNJ, a, b, t, expected_sign(FSGNJ, a, b), 1'b0);
            run_op("sign_injection", FSGNJN, a, b, t + 6'd1,
                   expected_sign(FSGNJN, a, b), 1'b0);
            run_op("sign_injection", FSGNJX, a, b, t + 6'd2,
                   expected_sign(FSGNJX, a, b), 1'b0);
            t = t + 6'd3;
        end
        close_test("sign_injection");
    endtask

    task automatic class_mask();
        logic [31:0] vals [0:9];

        // Ordered to match the mask bit positions
        vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000,
                 32'h0000_0000, 32'h0040_0000, 32'h3F80_0000, 32'h7F80_0000,
                 32'h7F80_0001, 32'h7FC0_0000};
        for (int i = 0; i < 10; i++) begin
            run_op("class_mask", FCLASS, vals[i], 32'h0, 6'(i), 32'd1 << i, 1'b0);
        end
        close_test("class_mask");
    endtask

    task automatic pipeline_flow();
        logic [31:0] held_result;
        logic [31:0] held_ctrl;

        // Back to back issue where each result shows two edges after its inputs
        drive_op(FSGNJX, 32'hBF80_0000, 32'hC000_0000, 6'h11);
        drive_op(FEQ, 32'h3F80_0000, 32'h3F80_0000, 6'h12);
        go_idle();
        expect_equal("pipeline_flow", "first valid", 1, valid_out);
        expect_equal("pipeline_flow", "first tag", 6'h11, tag_out);
        expect_equal("pipeline_flow", "first result", 32'h3F80_0000, result);
        @(posedge clk);
        #DRIVE_DELAY;
        expect_equal("pipeline_flow", "second valid", 1, valid_out);
        expect_equal("pipeline_flow", "second tag", 6'h12, tag_out);
        expect_equal("pipeline_flow", "second result", 32'h1, result);

        // Stall with a result on the output while new inputs are ignored
        run_op("pipeline_flow", FMAX, 32'h3F80_0000, 32'h4000_0000, 6'h21,
               32'h4000_0000, 1'b0);
        held_result = result;
        held_ctrl   = {tag_out, valid_out, invalid_out};
        stall       = 1'b1;
        valid       = 1'b1;
        operation   = FMIN;
        tag         = 6'h22;
        repeat (3) begin
            @(posedge clk);
            #DRIVE_DELAY;
            expect_equal("pipeline_flow", "held result", held_result, result);
            expect_equal("pipeline_flow", "held control", held_ctrl,
                         {tag_out, valid_out, invalid_out});
        end
        stall = 1'b0;
        valid = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #DRIVE_DELAY;
            expect_equal("pipeline_flow", "valid after stall", 0, valid_out);
            expect_equal("pipeline_flow", "idle result", 0, result);
            expect_equal("pipeline_flow", "idle tag and invalid", 0, {tag_out, invalid_out});
        end

        // Flush with one operation in the issue stage and one at the input
        drive_op(FLT, 32'h3F80_0000, 32'h4000_0000, 6'h31);
        drive_op(FLE, 32'h4000_0000, 32'h3F80_0000, 6'h32);
        flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        flush = 1'b0;
        valid = 1'b0;
        repeat (4) begin
            expect_equal("pipeline_flow", "valid after flush", 0, valid_out);
            expect_equal("pipeline_flow", "idle result", 0, result);
            expect_equal("pipeline_flow", "idle tag and invalid", 0, {tag_out, invalid_out});
            @(posedge clk);
            #DRIVE_DELAY;
        end
        close_test("pipeline_flow");
    endtask

// ======================================================================
// Sequence
// ======================================================================

    initial begin
        stall        = 1'b0;
        flush        = 1'b0;
        valid        = 1'b0;
        operation    = FEQ;
        operand_a    = '0;
        operand_b    = '0;
        tag          = '0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors  = 0;
        lfsr_state   = 16'd35935;

        after_reset();
        compare_ops();
        min_max_ops();
        sign_injection();
        class_mask();
        pipeline_flow();

        $display("tests run %0d, ok %0d, with errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_fpu

`default_nettype wire
